// File: source/sb_pkg.sv
package sb_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  // queue depth, pointers wrap so keep it a power of two
  localparam int unsigned NR_ENTRIES    = 8;
  localparam int unsigned TRANS_ID_BITS = $clog2(NR_ENTRIES);
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned NR_REGS       = 2 ** REG_ADDR_BITS;
  localparam int unsigned XLEN          = 32;
  localparam int unsigned EX_CAUSE_BITS = 4;

  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]          xlen_t;

  // unit that produces the result of an instruction
  typedef enum logic [2:0] {
    NONE,
    ALU,
    BRANCH,
    LOAD,
    STORE,
    MULT
  } fu_t;

  typedef struct packed {
    logic                     valid;
    logic [EX_CAUSE_BITS-1:0] cause;
  } exception_t;

  // ----------------------------------------
  // queue entry, write-back and stored slot
  // ----------------------------------------
  typedef struct packed {
    xlen_t      pc;
    trans_id_t  trans_id;
    fu_t        fu;
    reg_addr_t  rd;
    xlen_t      result;
    // result is ready
    logic       valid;
    exception_t ex;
  } sb_entry_t;

  typedef struct packed {
    logic       valid;
    trans_id_t  trans_id;
    xlen_t      data;
    exception_t ex;
  } wb_t;

  // issued marks a slot as in flight between allocation and commit
  typedef struct packed {
    logic      issued;
    sb_entry_t entry;
  } sb_slot_t;

endpackage

// File: source/sb_issue_ctrl.sv
`timescale 1ns/10ps

module sb_issue_ctrl import sb_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      flush_unissued_i,
  input  logic      unresolved_branch_i,
  input  logic      decoded_instr_valid_i,
  input  logic      issue_ack_i,
  input  logic      commit_ack_i,
  output trans_id_t issue_ptr_o,
  output trans_id_t commit_ptr_o,
  output logic      alloc_o,
  output logic      sb_full_o,
  output logic      issue_instr_valid_o,
  output logic      decoded_instr_ack_o
);

  trans_id_t                issue_ptr_q;
  trans_id_t                commit_ptr_q;
  logic [TRANS_ID_BITS-1:0] cnt_q;
  logic [TRANS_ID_BITS-1:0] cnt_d;
  logic                     full;

  // counter saturates at all ones, so one slot always stays free
  assign full      = &cnt_q;
  assign sb_full_o = full;

  // ----------------------------------------
  // issue handshake
  // ----------------------------------------
  // hold back while a branch is unresolved or no slot is left
  assign issue_instr_valid_o = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_instr_ack_o = issue_ack_i & ~full;
  // flush of un-issued instructions drops the acknowledged one
  assign alloc_o = decoded_instr_valid_i & decoded_instr_ack_o & ~flush_unissued_i;

  assign issue_ptr_o  = issue_ptr_q;
  assign commit_ptr_o = commit_ptr_q;

  // occupancy, up on allocation and down on commit
  assign cnt_d = cnt_q + TRANS_ID_BITS'(alloc_o) - TRANS_ID_BITS'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      // full flush, next instruction gets id 0
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      // pointers wrap on their own
      issue_ptr_q  <= issue_ptr_q + trans_id_t'(alloc_o);
      commit_ptr_q <= commit_ptr_q + trans_id_t'(commit_ack_i);
      cnt_q        <= cnt_d;
    end
  end

endmodule

// File: source/sb_entry_array.sv
`timescale 1ns/10ps

module sb_entry_array import sb_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           alloc_i,
  input  trans_id_t                      issue_ptr_i,
  input  sb_entry_t                      decoded_instr_i,
  input  wb_t                            wb_i,
  input  trans_id_t                      commit_ptr_i,
  input  logic                           commit_ack_i,
  output sb_slot_t [NR_ENTRIES-1:0]      slots_o,
  output sb_entry_t                      commit_instr_o
);

  // payload storage, flags are kept apart
  sb_entry_t               entry_q [NR_ENTRIES];
  logic [NR_ENTRIES-1:0]   issued_q, issued_d;
  logic [NR_ENTRIES-1:0]   valid_q, valid_d;
  logic [NR_ENTRIES-1:0]   exv_q, exv_d;
  logic                    wb_hit;

  // stale write-backs after a flush find no issued slot
  assign wb_hit = wb_i.valid & issued_q[wb_i.trans_id];

  // ----------------------------------------
  // flag next state
  // ----------------------------------------
  always_comb begin
    issued_d = issued_q;
    valid_d  = valid_q;
    exv_d    = exv_q;
    // new entry, result not yet there
    if (alloc_i) begin
      issued_d[issue_ptr_i] = 1'b1;
      valid_d[issue_ptr_i]  = 1'b0;
      exv_d[issue_ptr_i]    = decoded_instr_i.ex.valid;
    end
    // no unit behind it, finished one cycle after issue
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (issued_q[i] && entry_q[i].fu == NONE)
        valid_d[i] = 1'b1;
    end
    // write-back marks the result ready
    if (wb_hit) begin
      valid_d[wb_i.trans_id] = 1'b1;
      if (wb_i.ex.valid)
        exv_d[wb_i.trans_id] = 1'b1;
    end
    // commit frees the head slot
    if (commit_ack_i) begin
      issued_d[commit_ptr_i] = 1'b0;
      valid_d[commit_ptr_i]  = 1'b0;
    end
    if (flush_i) begin
      issued_d = '0;
      valid_d  = '0;
      exv_d    = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= '0;
      valid_q  <= '0;
      exv_q    <= '0;
    end else begin
      issued_q <= issued_d;
      valid_q  <= valid_d;
      exv_q    <= exv_d;
    end
  end

  // ----------------------------------------
  // payload
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_i)
      entry_q[issue_ptr_i] <= decoded_instr_i;
    if (wb_hit) begin
      entry_q[wb_i.trans_id].result <= wb_i.data;
      // keep the decode-time cause unless the unit reports one
      if (wb_i.ex.valid)
        entry_q[wb_i.trans_id].ex.cause <= wb_i.ex.cause;
    end
  end

  // slot view with live flags, id is the slot index
  always_comb begin
    for (int i = 0; i < NR_ENTRIES; i++) begin
      slots_o[i].issued         = issued_q[i];
      slots_o[i].entry          = entry_q[i];
      slots_o[i].entry.trans_id = trans_id_t'(i);
      slots_o[i].entry.valid    = valid_q[i];
      slots_o[i].entry.ex.valid = exv_q[i];
    end
  end

  // head of the queue
  assign commit_instr_o = slots_o[commit_ptr_i].entry;

endmodule

// File: source/sb_clobber.sv
`timescale 1ns/10ps

module sb_clobber import sb_pkg::*; (
  input  sb_slot_t [NR_ENTRIES-1:0] slots_i,
  output fu_t      [NR_REGS-1:0]    rd_clobber_o
);

  // ----------------------------------------
  // per-register match vectors
  // ----------------------------------------
  // bit i set when slot i is in flight and targets register r
  logic [NR_REGS-1:0][NR_ENTRIES-1:0] hit;

  always_comb begin
    hit = '0;
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (slots_i[i].issued)
        hit[slots_i[i].entry.rd][i] = 1'b1;
    end
    // x0 is never written
    hit[0] = '0;
  end

  // ----------------------------------------
  // fixed priority select
  // ----------------------------------------
  always_comb begin
    for (int r = 0; r < NR_REGS; r++) begin
      // default when nobody writes the register
      rd_clobber_o[r] = NONE;
      // walk downwards, so the lowest index is the last to win
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (hit[r][i])
          rd_clobber_o[r] = slots_i[i].entry.fu;
      end
    end
  end

endmodule

// File: source/sb_operand_fwd.sv
`timescale 1ns/10ps

module sb_operand_fwd import sb_pkg::*; (
  input  reg_addr_t                 rs1_i,
  input  reg_addr_t                 rs2_i,
  input  sb_slot_t [NR_ENTRIES-1:0] slots_i,
  input  wb_t                       wb_i,
  output xlen_t                     rs1_o,
  output xlen_t                     rs2_o,
  output logic                      rs1_valid_o,
  output logic                      rs2_valid_o
);

  // one lookup result
  typedef struct packed {
    logic  valid;
    xlen_t data;
  } fwd_t;

  fwd_t rs1_fwd;
  fwd_t rs2_fwd;

  // ----------------------------------------
  // lookup for one read port
  // ----------------------------------------
  function automatic fwd_t lookup(
    input reg_addr_t                 rs,
    input sb_slot_t [NR_ENTRIES-1:0] slots,
    input wb_t                       wb
  );
    fwd_t res;
    res = '0;
    // finished entries, lowest index wins
    for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
      if (slots[i].issued && slots[i].entry.valid && slots[i].entry.rd == rs) begin
        res.valid = 1'b1;
        res.data  = slots[i].entry.result;
      end
    end
    // write-back port beats stored results
    // a faulting unit has no usable data
    if (wb.valid && !wb.ex.valid && slots[wb.trans_id].entry.rd == rs) begin
      res.valid = 1'b1;
      res.data  = wb.data;
    end
    // x0 reads come from the register file
    if (rs == '0)
      res.valid = 1'b0;
    return res;
  endfunction

  always_comb begin
    rs1_fwd = lookup(rs1_i, slots_i, wb_i);
    rs2_fwd = lookup(rs2_i, slots_i, wb_i);
  end

  assign rs1_o       = rs1_fwd.data;
  assign rs1_valid_o = rs1_fwd.valid;
  assign rs2_o       = rs2_fwd.data;
  assign rs2_valid_o = rs2_fwd.valid;

endmodule

// File: source/scoreboard.sv
`timescale 1ns/10ps

module scoreboard import sb_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   flush_unissued_i,
  input  logic                   unresolved_branch_i,
  output logic                   sb_full_o,
  // unit that will write each register
  output fu_t [NR_REGS-1:0]      rd_clobber_o,
  // operand read ports
  input  reg_addr_t              rs1_i,
  output xlen_t                  rs1_o,
  output logic                   rs1_valid_o,
  input  reg_addr_t              rs2_i,
  output xlen_t                  rs2_o,
  output logic                   rs2_valid_o,
  // commit port
  output sb_entry_t              commit_instr_o,
  input  logic                   commit_ack_i,
  // from decode
  input  sb_entry_t              decoded_instr_i,
  input  logic                   decoded_instr_valid_i,
  output logic                   decoded_instr_ack_o,
  // to issue
  output sb_entry_t              issue_instr_o,
  output logic                   issue_instr_valid_o,
  input  logic                   issue_ack_i,
  // write-back port
  input  wb_t                    wb_i
);

  trans_id_t                 issue_ptr;
  trans_id_t                 commit_ptr;
  logic                      alloc;
  sb_slot_t [NR_ENTRIES-1:0] slots;

  // ----------------------------------------
  // pointers and handshakes
  // ----------------------------------------
  sb_issue_ctrl issue_ctrl_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_i      (flush_unissued_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .issue_ack_i           (issue_ack_i),
    .commit_ack_i          (commit_ack_i),
    .issue_ptr_o           (issue_ptr),
    .commit_ptr_o          (commit_ptr),
    .alloc_o               (alloc),
    .sb_full_o             (sb_full_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .decoded_instr_ack_o   (decoded_instr_ack_o)
  );

  // issue sees the decoded word tagged with its future slot
  always_comb begin
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_ptr;
  end

  // ----------------------------------------
  // storage and lookups
  // ----------------------------------------
  sb_entry_array entry_array_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .alloc_i         (alloc),
    .issue_ptr_i     (issue_ptr),
    .decoded_instr_i (decoded_instr_i),
    .wb_i            (wb_i),
    .commit_ptr_i    (commit_ptr),
    .commit_ack_i    (commit_ack_i),
    .slots_o         (slots),
    .commit_instr_o  (commit_instr_o)
  );

  sb_clobber clobber_inst (
    .slots_i      (slots),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd operand_fwd_inst (
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .slots_i     (slots),
    .wb_i        (wb_i),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

// File: tb/scoreboard_sva.sv
`timescale 1ns/10ps

module scoreboard_sva import sb_pkg::*; (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              sb_full_o,
  input logic              commit_ack_i,
  input sb_entry_t         commit_instr_o,
  input logic              issue_ack_i,
  input logic              issue_instr_valid_o,
  input fu_t [NR_REGS-1:0] rd_clobber_o
);

  // ----------------------------------------
  // handshake rules
  // ----------------------------------------
  // commit stage only takes a head entry whose result is ready
  commit_ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> commit_instr_o.valid)
    else $error("commit acknowledged while the head entry is not valid");

  // issue stage only answers an offered instruction
  // while full it may hold its ack, the scoreboard drops it then
  issue_ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_ack_i && !sb_full_o) |-> issue_instr_valid_o)
    else $error("issue acknowledged while no instruction was offered");

  // ----------------------------------------
  // clobber table
  // ----------------------------------------
  // x0 has no producer
  x0_never_clobbered: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o[0] == NONE)
    else $error("register 0 shows a functional unit in the clobber table");

endmodule

// File: tb/tb_scoreboard.sv
`timescale 1ns/10ps

module tb_scoreboard import sb_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  // rough length of the whole stimulus in cycles
  localparam int STIM_CYCLES  = 300;
  localparam int WAIT_LIMIT   = 32;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  logic              flush_unissued_i;
  logic              unresolved_branch_i;
  logic              sb_full_o;
  fu_t [NR_REGS-1:0] rd_clobber_o;
  reg_addr_t         rs1_i;
  xlen_t             rs1_o;
  logic              rs1_valid_o;
  reg_addr_t         rs2_i;
  xlen_t             rs2_o;
  logic              rs2_valid_o;
  sb_entry_t         commit_instr_o;
  logic              commit_ack_i;
  sb_entry_t         decoded_instr_i;
  logic              decoded_instr_valid_i;
  logic              decoded_instr_ack_o;
  sb_entry_t         issue_instr_o;
  logic              issue_instr_valid_o;
  logic              issue_ack_i;
  wb_t               wb_i;

  // reference model, one entry per slot
  logic [NR_ENTRIES-1:0]       m_issued;
  logic [NR_ENTRIES-1:0]       m_done;
  fu_t [NR_ENTRIES-1:0]        m_fu;
  reg_addr_t [NR_ENTRIES-1:0]  m_rd;
  xlen_t [NR_ENTRIES-1:0]      m_result;
  // exception the head should carry at commit
  exception_t [NR_ENTRIES-1:0] m_ex;
  trans_id_t                   m_tail;
  trans_id_t                   exp_head;
  int                          m_count;
  // in-flight ids in allocation order
  trans_id_t                   order_q[$];
  // ids still waiting for a write-back
  trans_id_t                   pending[$];

  logic              exp_full;
  logic              exp_dec_ack;
  logic              exp_issue_valid;
  logic              exp_alloc;
  logic              exp_commit_valid;
  fu_t [NR_REGS-1:0] exp_clobber;
  logic [XLEN:0]     exp_rs1;
  logic [XLEN:0]     exp_rs2;
  logic [XLEN:0]     act_rs1;
  logic [XLEN:0]     act_rs2;

  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int unsigned lcg_state = 32'd11246;

  scoreboard scoreboard_inst (.*);

  bind scoreboard scoreboard_sva scoreboard_sva_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .sb_full_o           (sb_full_o),
    .commit_ack_i        (commit_ack_i),
    .commit_instr_o      (commit_instr_o),
    .issue_ack_i         (issue_ack_i),
    .issue_instr_valid_o (issue_instr_valid_o),
    .rd_clobber_o        (rd_clobber_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni || flush_i) begin
      m_issued <= '0;
      m_done   <= '0;
      m_tail   <= '0;
      exp_head <= '0;
      m_count  <= 0;
      order_q.delete();
    end else begin
      // entries with no unit finish on their own
      for (int i = 0; i < NR_ENTRIES; i++) begin
        if (m_issued[i] && m_fu[i] == NONE)
          m_done[i] <= 1'b1;
      end
      if (wb_i.valid && m_issued[wb_i.trans_id]) begin
        m_done[wb_i.trans_id]   <= 1'b1;
        m_result[wb_i.trans_id] <= wb_i.data;
        if (wb_i.ex.valid)
          m_ex[wb_i.trans_id] <= wb_i.ex;
      end
      if (exp_alloc) begin
        m_issued[m_tail] <= 1'b1;
        m_done[m_tail]   <= 1'b0;
        m_fu[m_tail]     <= decoded_instr_i.fu;
        m_rd[m_tail]     <= decoded_instr_i.rd;
        m_result[m_tail] <= decoded_instr_i.result;
        m_ex[m_tail]     <= decoded_instr_i.ex;
        order_q.push_back(m_tail);
      end
      if (commit_ack_i) begin
        m_issued[exp_head] <= 1'b0;
        m_done[exp_head]   <= 1'b0;
        void'(order_q.pop_front());
      end
      m_tail   <= m_tail + trans_id_t'(exp_alloc);
      m_count  <= order_q.size();
      // an empty queue has its head at the tail
      exp_head <= (order_q.size() == 0) ? m_tail : order_q[0];
    end
  end

  // {valid, data} that a read port should show
  function automatic logic [XLEN:0] expect_operand(input reg_addr_t rs);
    logic [XLEN:0] res;
    res = '0;
    for (int i = int'(NR_ENTRIES) - 1; i >= 0; i--) begin
      if (m_issued[i] && m_done[i] && m_rd[i] == rs)
        res = {1'b1, m_result[i]};
    end
    // clean write-back in this cycle beats stored results
    if (wb_i.valid && !wb_i.ex.valid && m_rd[wb_i.trans_id] == rs)
      res = {1'b1, wb_i.data};
    if (rs == '0)
      res = '0;
    return res;
  endfunction

  always_comb begin
    exp_full         = (m_count == NR_ENTRIES - 1);
    exp_dec_ack      = issue_ack_i && !exp_full;
    exp_issue_valid  = decoded_instr_valid_i && !unresolved_branch_i && !exp_full;
    exp_alloc        = decoded_instr_valid_i && exp_dec_ack && !flush_unissued_i;
    exp_commit_valid = m_issued[exp_head] && m_done[exp_head];
    for (int r = 0; r < NR_REGS; r++)
      exp_clobber[r] = NONE;
    // lowest slot index written last, so it wins
    for (int i = int'(NR_ENTRIES) - 1; i >= 0; i--) begin
      if (m_issued[i])
        exp_clobber[m_rd[i]] = m_fu[i];
    end
    exp_clobber[0] = NONE;
    exp_rs1 = expect_operand(rs1_i);
    exp_rs2 = expect_operand(rs2_i);
  end

  // data only counts while the port says valid
  assign act_rs1 = {rs1_valid_o, rs1_valid_o ? rs1_o : xlen_t'(0)};
  assign act_rs2 = {rs2_valid_o, rs2_valid_o ? rs2_o : xlen_t'(0)};

  task automatic flag_mismatch(input string name, input string got, input string want);
    mismatch_cnt++;
    $display("Mismatch at %0t: %s is %s, expected %s", $time, name, got, want);
  endtask

  task automatic note_failure(input string what);
    other_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // ----------------------------------------
  // checks against the model
  // ----------------------------------------
  full_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) sb_full_o == exp_full)
    else flag_mismatch("sb_full_o", $sformatf("%h", $sampled(sb_full_o)),
      $sformatf("%h", $sampled(exp_full)));
  dec_ack_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    decoded_instr_ack_o == exp_dec_ack)
    else flag_mismatch("decoded_instr_ack_o", $sformatf("%h", $sampled(decoded_instr_ack_o)),
      $sformatf("%h", $sampled(exp_dec_ack)));
  issue_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_instr_valid_o == exp_issue_valid)
    else flag_mismatch("issue_instr_valid_o", $sformatf("%h", $sampled(issue_instr_valid_o)),
      $sformatf("%h", $sampled(exp_issue_valid)));
  issue_id_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_instr_o.trans_id == m_tail)
    else flag_mismatch("issue_instr_o.trans_id", $sformatf("%h", $sampled(issue_instr_o.trans_id)),
      $sformatf("%h", $sampled(m_tail)));
  commit_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_instr_o.valid == exp_commit_valid)
    else flag_mismatch("commit_instr_o.valid", $sformatf("%h", $sampled(commit_instr_o.valid)),
      $sformatf("%h", $sampled(exp_commit_valid)));
  commit_id_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_instr_o.trans_id == exp_head)
    else flag_mismatch("commit_instr_o.trans_id",
      $sformatf("%h", $sampled(commit_instr_o.trans_id)), $sformatf("%h", $sampled(exp_head)));
  commit_data_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !exp_commit_valid || commit_instr_o.result == m_result[exp_head])
    else flag_mismatch("commit_instr_o.result", $sformatf("%h", $sampled(commit_instr_o.result)),
      $sformatf("%h", $sampled(m_result[exp_head])));
  commit_ex_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !exp_commit_valid || commit_instr_o.ex == m_ex[exp_head])
    else flag_mismatch("commit_instr_o.ex", $sformatf("%h", $sampled(commit_instr_o.ex)),
      $sformatf("%h", $sampled(m_ex[exp_head])));
  clobber_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o == exp_clobber)
    else flag_mismatch("rd_clobber_o", $sformatf("%h", $sampled(rd_clobber_o)),
      $sformatf("%h", $sampled(exp_clobber)));
  rs1_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) act_rs1 == exp_rs1)
    else flag_mismatch("rs1_valid_o/rs1_o", $sformatf("%h", $sampled(act_rs1)),
      $sformatf("%h", $sampled(exp_rs1)));
  rs2_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) act_rs2 == exp_rs2)
    else flag_mismatch("rs2_valid_o/rs2_o", $sformatf("%h", $sampled(act_rs2)),
      $sformatf("%h", $sampled(exp_rs2)));

  // ----------------------------------------
  // stimulus helpers, all driven on the falling edge
  // ----------------------------------------
  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
  endfunction

  task automatic idle_inputs();
    flush_i               = 1'b0;
    flush_unissued_i      = 1'b0;
    unresolved_branch_i   = 1'b0;
    rs1_i                 = '0;
    rs2_i                 = '0;
    commit_ack_i          = 1'b0;
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    issue_ack_i           = 1'b0;
    wb_i                  = '0;
  endtask

  task automatic drive_decoded(input fu_t fu, input reg_addr_t rd);
    decoded_instr_i        = '0;
    decoded_instr_i.pc     = next_rand();
    decoded_instr_i.fu     = fu;
    decoded_instr_i.rd     = rd;
    decoded_instr_i.result = next_rand();
    decoded_instr_valid_i  = 1'b1;
  endtask

  // one accepted instruction, waits out a full queue
  task automatic issue_one(input fu_t fu, input reg_addr_t rd);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (sb_full_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (sb_full_o)
      note_failure("queue stayed full, instruction could not be issued");
    if (fu != NONE)
      pending.push_back(m_tail);
    drive_decoded(fu, rd);
    // watch the new target while its producer is still out
    rs2_i       = rd;
    issue_ack_i = 1'b1;
    @(negedge clk_i);
    decoded_instr_valid_i = 1'b0;
    issue_ack_i           = 1'b0;
  endtask

  // valid decoded word held for some cycles under given side conditions
  task automatic offer_decoded(input int cycles, input logic ack, input logic branch,
                               input logic drop);
    @(negedge clk_i);
    drive_decoded(ALU, reg_addr_t'(next_rand()));
    issue_ack_i         = ack;
    unresolved_branch_i = branch;
    flush_unissued_i    = drop;
    repeat (cycles) @(negedge clk_i);
    idle_inputs();
  endtask

  // result for one slot, read ports watch its rd
  task automatic write_back(input trans_id_t id);
    @(negedge clk_i);
    wb_i          = '0;
    wb_i.valid    = 1'b1;
    wb_i.trans_id = id;
    wb_i.data     = next_rand();
    // now and then the unit reports a fault
    if (next_rand() % 4 == 0) begin
      wb_i.ex.valid = 1'b1;
      wb_i.ex.cause = EX_CAUSE_BITS'(next_rand());
    end
    rs1_i         = m_rd[id];
    rs2_i         = reg_addr_t'(next_rand());
    @(negedge clk_i);
    wb_i.valid = 1'b0;
  endtask

  task automatic pick_write_back();
    int idx;
    idx = int'(next_rand() % pending.size());
    write_back(pending[idx]);
    pending.delete(idx);
  endtask

  task automatic commit_one();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!commit_instr_o.valid && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!commit_instr_o.valid) begin
      note_failure("head entry never became ready to commit");
    end else begin
      commit_ack_i = 1'b1;
      @(negedge clk_i);
      commit_ack_i = 1'b0;
    end
  endtask

  task automatic drain();
    for (int i = 0; i < NR_ENTRIES && m_count != 0; i++)
      commit_one();
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    idle_inputs();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // out-of-order write-back, in-order commit, ids wrap
    repeat (6) begin
      repeat (5) issue_one(fu_t'(next_rand() % 32'd6), reg_addr_t'(next_rand()));
      while (pending.size() != 0)
        pick_write_back();
      drain();
    end
    // fill up, ack is dropped while full, one commit frees a slot
    repeat (NR_ENTRIES - 1) issue_one(NONE, reg_addr_t'(next_rand()));
    offer_decoded(3, 1'b1, 1'b0, 1'b0);
    commit_one();
    drain();
    // held back by a branch, then dropped by a partial flush
    offer_decoded(3, 1'b0, 1'b1, 1'b0);
    offer_decoded(1, 1'b1, 1'b0, 1'b1);
    // full flush with work in flight
    repeat (3) issue_one(ALU, reg_addr_t'(next_rand()));
    pick_write_back();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    pending.delete();
    // x0 target, never clobbered and never forwarded
    issue_one(LOAD, '0);
    pick_write_back();
    drain();
    repeat (4) @(negedge clk_i);
    $display("closing counts: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // stimulus length with a margin of two
  initial begin
    #(STIM_CYCLES * CLK_PERIOD * 2);
    $display("watchdog expired at %0t, the run did not finish in time", $time);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: list.f
source/sb_pkg.sv
source/sb_issue_ctrl.sv
source/sb_entry_array.sv
source/sb_clobber.sv
source/sb_operand_fwd.sv
source/scoreboard.sv
tb/scoreboard_sva.sv
tb/tb_scoreboard.sv

// File: run.sh
#!/bin/sh
# build and run the scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_scoreboard -f list.f -o tb_scoreboard_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_scoreboard_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$log"; then
  exit 0
fi
exit 1
